// ==== src/audio_pkg.sv ====
package audio_pkg;

	// microphone side
	localparam int SAMPLE_W = 8;
	typedef logic signed [SAMPLE_W-1:0] sample_t; // one adc sample, two's complement

	// speaker side
	localparam int AMP_W = 16;
	typedef logic signed [AMP_W-1:0] amp_t;

	// magnitude of the tone burst
	// kept well under full scale so the negated value never wraps
	localparam logic [AMP_W-1:0] BURST_AMP = 16'd12000;

	// window energy is a plain sum of |sample|
	// 20 bits covers windows far longer than the default of 8 steps
	localparam int ENERGY_W = 20;
	typedef logic [ENERGY_W-1:0] energy_t;

endpackage

// ==== src/ranging_pkg.sv ====
package ranging_pkg;

	// measurement sequencing
	typedef enum logic [2:0] {
		IDLE,        // waiting for trigger, result held
		FIRE,        // one clock, launches the burst
		AWAIT_BURST, // speaker busy
		LISTEN,      // counting steps, watching for an onset
		REST         // quiet gap before the next attempt
	} range_state_t;

	// step counts
	localparam int DELAY_W = 12;
	typedef logic [DELAY_W-1:0] delay_t;

	localparam int ATTEMPT_W = 4;
	typedef logic [ATTEMPT_W-1:0] attempt_t; // saturates at all ones

	// history filler, never a real result
	localparam delay_t NO_DELAY = '1;

endpackage

// ==== src/impulse_generator.sv ====
`timescale 1ns/1ps

module impulse_generator import audio_pkg::*; #(
	parameter int BURST_LEN = 4
) (
	input logic clk_in,
	input logic rst_in,
	input logic step_in,
	input logic fire,
	output logic burst_done,
	output amp_t amp_out
);

	localparam int CNT_W = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;
	localparam amp_t POS_AMP = amp_t'(BURST_AMP);
	localparam amp_t NEG_AMP = -POS_AMP;

	logic active;
	logic phase; // 0 -> positive half
	logic [CNT_W-1:0] step_cnt;
	logic last_step;

	assign last_step = (step_cnt == CNT_W'(BURST_LEN - 1));

	// last step of the burst, same clock as the strobe
	assign burst_done = active && step_in && last_step;

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			active <= 1'b0;
			phase <= 1'b0;
			step_cnt <= '0;
		end else if (!active) begin
			if (fire) begin // retrigger during a burst is dropped
				active <= 1'b1;
				phase <= 1'b0;
				step_cnt <= '0;
			end
		end else if (step_in) begin
			if (last_step) begin
				active <= 1'b0;
			end else begin
				step_cnt <= step_cnt + 1'b1;
				phase <= ~phase; // flip sign every step
			end
		end
	end

	always_comb begin
		if (!active)
			amp_out = '0;
		else
			amp_out = phase ? NEG_AMP : POS_AMP;
	end

endmodule

// ==== src/onset_detector.sv ====
`timescale 1ns/1ps

module onset_detector import audio_pkg::*; #(
	parameter int WINDOW_SIZE = 8
) (
	input logic clk_in,
	input logic rst_in,
	input logic step_in,
	input logic enable,
	input logic det_clr,
	input sample_t mic_in,
	output logic onset
);

	localparam int IX_W = (WINDOW_SIZE > 1) ? $clog2(WINDOW_SIZE) : 1;

	logic [IX_W-1:0] win_ix;
	energy_t cur_sum;
	energy_t prev_sum;      // last closed window
	energy_t prev_prev_sum; // the one before that

	logic [SAMPLE_W-1:0] mag;
	energy_t sum_next;
	logic [ENERGY_W:0] older_ext;
	logic [ENERGY_W:0] older_scaled;
	logic win_close;
	logic is_onset;

	// |x|, -128 maps to 128 as unsigned
	assign mag = mic_in[SAMPLE_W-1] ? -mic_in : mic_in;

	assign sum_next = cur_sum + ENERGY_W'(mag);
	assign win_close = (win_ix == IX_W'(WINDOW_SIZE - 1));

	// 1.5x older sum, one extra bit so all ones can't wrap
	assign older_ext = {1'b0, prev_prev_sum};
	assign older_scaled = older_ext + (older_ext >> 1);

	assign is_onset = (sum_next > prev_sum) && ({1'b0, sum_next} > older_scaled);

	always_ff @(posedge clk_in) begin
		onset <= 1'b0;
		if (rst_in || det_clr) begin
			// all ones so the first two windows can never fire
			prev_sum <= '1;
			prev_prev_sum <= '1;
			cur_sum <= '0;
			win_ix <= '0;
		end else if (enable && step_in) begin
			if (win_close) begin
				onset <= is_onset;
				prev_prev_sum <= prev_sum;
				prev_sum <= sum_next; // includes this step
				cur_sum <= '0;
				win_ix <= '0;
			end else begin
				cur_sum <= sum_next;
				win_ix <= win_ix + 1'b1;
			end
		end
	end

endmodule

// ==== src/interval_timer.sv ====
`timescale 1ns/1ps

module interval_timer import ranging_pkg::*; #(
	parameter int MAX_DELAY = 256,
	parameter int REST_STEPS = 32
) (
	input logic clk_in,
	input logic rst_in,
	input logic step_in,
	input logic listen_clr,
	input logic listen_en,
	input logic rest_start,
	output delay_t listen_count,
	output logic listen_expired,
	output logic rest_done
);

	localparam int REST_W = $clog2(REST_STEPS + 1);

	logic [REST_W-1:0] rest_cnt; // steps left in the rest
	logic resting;

	assign listen_expired = step_in && (listen_count == delay_t'(MAX_DELAY));

	// listening interval, 1 on the first enabled step
	always_ff @(posedge clk_in) begin
		if (rst_in || listen_clr)
			listen_count <= '0;
		else if (listen_en && step_in)
			listen_count <= listen_count + 1'b1;
	end

	always_ff @(posedge clk_in) begin
		rest_done <= 1'b0;
		if (rst_in) begin
			resting <= 1'b0;
			rest_cnt <= '0;
		end else if (rest_start) begin
			resting <= 1'b1;
			rest_cnt <= REST_W'(REST_STEPS);
		end else if (resting && step_in) begin
			if (rest_cnt == REST_W'(1)) begin
				resting <= 1'b0;
				rest_done <= 1'b1;
			end
			rest_cnt <= rest_cnt - 1'b1;
		end
	end

endmodule

// ==== src/ranging_fsm.sv ====
`timescale 1ns/1ps

module ranging_fsm import ranging_pkg::*; (
	input logic clk_in,
	input logic rst_in,
	input logic trigger,
	input logic burst_done,
	input logic onset,
	input logic listen_expired,
	input logic rest_done,
	input delay_t listen_count,
	output logic fire,
	output logic det_clr,
	output logic listen_clr,
	output logic listen_en,
	output logic rest_start,
	output delay_t delay,
	output logic delay_valid,
	output logic busy,
	output attempt_t attempts
);

	range_state_t state;

	delay_t hist_new; // previous attempt result
	delay_t hist_old; // the one before
	logic start_listen;
	logic confirmed;

	// FIRE lasts exactly one clock
	assign fire = (state == FIRE);
	assign listen_en = (state == LISTEN);
	assign busy = (state != IDLE);

	// clear detector and timer as the burst finishes
	assign start_listen = (state == AWAIT_BURST) && burst_done;
	assign det_clr = start_listen;
	assign listen_clr = start_listen;

	// third matching result in a row
	assign confirmed = (hist_new == listen_count) && (hist_old == listen_count);

	always_ff @(posedge clk_in) begin
		rest_start <= 1'b0;
		if (rst_in) begin
			state <= IDLE;
			delay <= '0;
			delay_valid <= 1'b0;
			attempts <= '0;
			hist_new <= NO_DELAY;
			hist_old <= NO_DELAY;
		end else begin
			case (state)
				IDLE: begin
					if (trigger) begin
						delay_valid <= 1'b0;
						attempts <= '0;
						hist_new <= NO_DELAY;
						hist_old <= NO_DELAY;
						state <= FIRE;
					end
				end
				FIRE: begin
					if (attempts != '1)
						attempts <= attempts + 1'b1;
					state <= AWAIT_BURST;
				end
				AWAIT_BURST: begin
					if (burst_done)
						state <= LISTEN;
				end
				LISTEN: begin
					if (onset) begin
						hist_old <= hist_new;
						hist_new <= listen_count;
						if (confirmed) begin
							delay <= listen_count;
							delay_valid <= 1'b1;
							state <= IDLE;
						end else begin
							rest_start <= 1'b1;
							state <= REST;
						end
					end else if (listen_expired) begin // miss, history kept
						rest_start <= 1'b1;
						state <= REST;
					end
				end
				REST: begin
					if (rest_done)
						state <= FIRE;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// ==== src/sonar_top.sv ====
`timescale 1ns/1ps

module sonar_top import audio_pkg::*, ranging_pkg::*; #(
	parameter int WINDOW_SIZE = 8,  // steps per energy window
	parameter int MAX_DELAY = 256,  // listening steps before a miss
	parameter int REST_STEPS = 32,
	parameter int BURST_LEN = 4
) (
	input logic clk_in,
	input logic rst_in,
	input logic step_in,
	input logic trigger,
	input sample_t mic_in,
	output amp_t amp_out,
	output delay_t delay,
	output logic delay_valid,
	output logic busy,
	output attempt_t attempts
);

	logic fire, burst_done;
	logic det_clr, onset;
	logic listen_clr, listen_en, listen_expired;
	logic rest_start, rest_done;
	delay_t listen_count;

	impulse_generator #(.BURST_LEN(BURST_LEN)) impulse_generator_inst (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.step_in(step_in),
		.fire(fire),
		.burst_done(burst_done),
		.amp_out(amp_out)
	);

	// detector only runs while listening
	onset_detector #(.WINDOW_SIZE(WINDOW_SIZE)) onset_detector_inst (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.step_in(step_in),
		.enable(listen_en),
		.det_clr(det_clr),
		.mic_in(mic_in),
		.onset(onset)
	);

	interval_timer #(
		.MAX_DELAY(MAX_DELAY),
		.REST_STEPS(REST_STEPS)
	) interval_timer_inst (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.step_in(step_in),
		.listen_clr(listen_clr),
		.listen_en(listen_en),
		.rest_start(rest_start),
		.listen_count(listen_count),
		.listen_expired(listen_expired),
		.rest_done(rest_done)
	);

	ranging_fsm ranging_fsm_inst (
		.clk_in(clk_in),
		.rst_in(rst_in),
		.trigger(trigger),
		.burst_done(burst_done),
		.onset(onset),
		.listen_expired(listen_expired),
		.rest_done(rest_done),
		.listen_count(listen_count),
		.fire(fire),
		.det_clr(det_clr),
		.listen_clr(listen_clr),
		.listen_en(listen_en),
		.rest_start(rest_start),
		.delay(delay),
		.delay_valid(delay_valid),
		.busy(busy),
		.attempts(attempts)
	);

endmodule

// ==== test/sonar_tb.sv ====
`timescale 1ns/1ps

module sonar_tb import audio_pkg::*, ranging_pkg::*; ();

	localparam int WIN = 8;
	localparam int BURST = 4;
	localparam int TIMEOUT = 20000; // clocks allowed per wait
	localparam int LOUD = 100;

	logic clk_in = 1'b0;
	logic rst_in = 1'b1;
	logic step_in = 1'b0;
	logic trigger = 1'b0;
	sample_t mic_in = '0;
	amp_t amp_out;
	delay_t delay;
	logic delay_valid;
	logic busy;
	attempt_t attempts;

	int errors = 0;
	int checks = 0;
	int mon_errors = 0; // raised by the echo model
	int echo_sched[4];  // echo step per attempt, 0 is silence
	int echo_sign = 1;
	int bursts_total = 0;

	// echo model state
	int attempt_ix, echo_at, listen_step, step_phase;
	int amp_now, last_amp, burst_steps, noise;
	bit in_burst, listening;
	logic [31:0] rng_state = 32'h6246;

	sonar_top #(
		.WINDOW_SIZE(WIN),
		.MAX_DELAY(256),
		.REST_STEPS(32),
		.BURST_LEN(BURST)
	) sonar_top_inst (.*);

	always #10 clk_in = ~clk_in;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// step count at the close of the window holding step k
	function automatic int window_end(input int k);
		return ((k + WIN - 1) / WIN) * WIN;
	endfunction

	// burst monitor and echo model
	always @(negedge clk_in) begin
		amp_now = int'(amp_out);
		if (!busy)
			attempt_ix = 0;
		if (rst_in) begin
			in_burst = 1'b0;
			listening = 1'b0;
		end else if (amp_now != 0) begin
			if (!in_burst) begin
				in_burst = 1'b1;
				listening = 1'b0;
				burst_steps = 1;
				assert (amp_now == int'(BURST_AMP)) else begin
					mon_errors++;
					$display("** Error at %0t: burst starts at %0d", $time, amp_now);
				end
			end else if (amp_now != last_amp) begin
				burst_steps++;
				assert (amp_now == -last_amp) else begin
					mon_errors++;
					$display("** Error at %0t: burst gives %0d after %0d", $time, amp_now,
						last_amp);
				end
			end
			last_amp = amp_now;
		end else if (in_burst) begin // back to 0, listening starts
			in_burst = 1'b0;
			assert (burst_steps == BURST) else begin
				mon_errors++;
				$display("** Error at %0t: burst of %0d steps, expected %0d", $time,
					burst_steps, BURST);
			end
			echo_at = (attempt_ix < 4) ? echo_sched[attempt_ix] : 0;
			attempt_ix++;
			bursts_total++;
			listening = 1'b1;
			listen_step = 0;
		end
		step_phase = (step_phase + 1) % 4;
		step_in = (step_phase == 0); // one clock in four
		rng_state = lcg_next(rng_state);
		// magnitude 2 or 3, so a quiet window never beats 1.5x another one
		noise = 2 + int'(rng_state[16]);
		if (rng_state[24])
			noise = -noise;
		if (step_in && listening)
			listen_step++;
		if (listening && echo_at != 0 && listen_step >= echo_at)
			mic_in = sample_t'(LOUD * echo_sign);
		else
			mic_in = sample_t'(noise);
	end

	task automatic check_value(input int got, input int exp, input string what);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic apply_reset();
		rst_in = 1'b1;
		repeat (5) @(negedge clk_in);
		rst_in = 1'b0;
	endtask

	task automatic pulse_trigger();
		@(negedge clk_in);
		trigger = 1'b1;
		@(negedge clk_in);
		trigger = 1'b0;
	endtask

	// busy has to stay up until delay_valid rises
	task automatic wait_result();
		int n;
		int low_cycles;
		n = 0;
		low_cycles = 0;
		while (!delay_valid && n < TIMEOUT) begin
			if (!busy)
				low_cycles++;
			@(negedge clk_in);
			n++;
		end
		assert (delay_valid) else begin
			errors++;
			$display("timed out after %0d clocks waiting for a confirmed range", TIMEOUT);
		end
		check_value(low_cycles, 0, "clocks with busy low");
		check_value(int'(busy), 0, "busy at result");
	endtask

	task automatic wait_attempts(input int target);
		int n;
		n = 0;
		while (int'(attempts) != target && n < TIMEOUT) begin
			@(negedge clk_in);
			n++;
		end
		assert (int'(attempts) == target) else begin
			errors++;
			$display("timed out waiting for attempt %0d to start", target);
		end
	endtask

	task automatic measure(input int exp_delay, input int exp_attempts);
		pulse_trigger();
		wait_result();
		check_value(int'(delay), exp_delay, "delay");
		check_value(int'(attempts), exp_attempts, "attempts");
	endtask

	task automatic test_reset_idle();
		int drops;
		apply_reset();
		check_value(int'(delay_valid), 0, "delay_valid after reset");
		check_value(int'(busy), 0, "busy after reset");
		check_value(int'(attempts), 0, "attempts after reset");
		check_value(int'(amp_out), 0, "amp_out after reset");
		echo_sched = '{25, 25, 25, 25};
		pulse_trigger();
		wait_attempts(2);
		pulse_trigger(); // should be ignored, FSM is busy
		check_value(int'(attempts), 2, "attempts after trigger while busy");
		measure_done: begin
			wait_result();
			check_value(int'(attempts), 3, "attempts");
			check_value(int'(delay), window_end(25), "delay");
		end
		drops = 0;
		repeat (40) begin
			@(negedge clk_in);
			if (!delay_valid)
				drops++;
		end
		check_value(drops, 0, "idle clocks with delay_valid low");
		echo_sched = '{41, 41, 41, 41};
		pulse_trigger();
		check_value(int'(delay_valid), 0, "delay_valid after new trigger");
		wait_result();
		check_value(int'(delay), window_end(41), "delay of second range");
	endtask

	task automatic test_miss_retry();
		int bursts_before;
		apply_reset();
		bursts_before = bursts_total;
		echo_sched = '{0, 25, 25, 25}; // first attempt hears nothing
		measure(window_end(25), 4);
		check_value(bursts_total - bursts_before, 4, "bursts played");
	endtask

	initial begin
		apply_reset();
		test_reset_idle();
		// basic range, echo just past the third window
		apply_reset();
		echo_sched = '{3 * WIN + 1, 3 * WIN + 1, 3 * WIN + 1, 3 * WIN + 1};
		measure(window_end(3 * WIN + 1), 3);
		apply_reset();
		echo_sched = '{41, 25, 25, 25};
		measure(window_end(25), 4);
		test_miss_retry();
		apply_reset();
		echo_sign = -1; // energy must not care about sign
		echo_sched = '{25, 25, 25, 25};
		measure(window_end(25), 3);
		echo_sign = 1;
		$display("checks: %0d, errors: %0d, echo model errors: %0d", checks, errors,
			mon_errors);
		if (errors + mon_errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== flist.f ====
src/audio_pkg.sv
src/ranging_pkg.sv
src/impulse_generator.sv
src/onset_detector.sv
src/interval_timer.sv
src/ranging_fsm.sv
src/sonar_top.sv
test/sonar_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the sonar testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module sonar_tb \
	--Mdir obj_dir \
	-o sonar_sim \
	-f flist.f

./obj_dir/sonar_sim | tee sim.log

if grep -qx "No errors" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
